// ==== sim/mpmem_testdata.txt ====
// Columns: op, strobe/addr/data for write ports 0..2, strobe/addr for read ports 0..1,
// expected data for read ports 0..1, check flags (bit r checks read port r).
// Op 1 drives one cycle, op 2 ends a section with an idle gap, op 0 ends the data.
// Unwritten addresses read as zero.
1 0 00 00000000 0 00 00000000 0 00 00000000 1 10 1 20 00000000 00000000 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 7f 1 ff 00000000 00000000 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 00 1 80 00000000 00000000 3
2 0 00 00000000 0 00 00000000 0 00 00000000 0 00 0 00 00000000 00000000 0
// Each write port fills its own addresses, both read ports read every bank.
1 1 01 a0a00001 1 02 b1b10002 1 03 c2c20003 0 00 0 00 00000000 00000000 0
1 1 11 a0a00011 1 12 b1b10012 1 13 c2c20013 1 01 1 02 a0a00001 b1b10002 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 03 1 01 c2c20003 a0a00001 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 02 1 03 b1b10002 c2c20003 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 11 1 12 a0a00011 b1b10012 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 13 1 11 c2c20013 a0a00011 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 12 1 13 b1b10012 c2c20013 3
2 0 00 00000000 0 00 00000000 0 00 00000000 0 00 0 00 00000000 00000000 0
// Same address from several write ports, the highest port wins.
1 1 40 11110040 1 40 22220040 1 40 33330040 0 00 0 00 00000000 00000000 0
1 1 41 11110041 1 41 22220041 0 00 00000000 1 40 1 40 33330040 33330040 3
1 1 42 11110042 1 43 22220043 1 42 33330042 1 41 1 41 22220041 22220041 3
1 1 40 44440040 0 00 00000000 0 00 00000000 1 42 1 43 33330042 22220043 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 40 1 42 44440040 33330042 3
2 0 00 00000000 0 00 00000000 0 00 00000000 0 00 0 00 00000000 00000000 0
// Read and write of one address in one cycle return the old word.
1 0 00 00000000 1 50 55550050 0 00 00000000 1 50 1 50 00000000 00000000 3
1 0 00 00000000 0 00 00000000 1 50 66660050 1 50 1 50 55550050 55550050 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 50 1 50 66660050 66660050 3
1 0 00 00000000 0 00 00000000 1 01 77770001 1 01 1 01 a0a00001 a0a00001 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 01 1 01 77770001 77770001 3
2 0 00 00000000 0 00 00000000 0 00 00000000 0 00 0 00 00000000 00000000 0
// Back-to-back reads on both ports.
1 1 60 e0e00060 1 61 e1e10061 1 62 e2e20062 1 11 1 42 a0a00011 33330042 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 12 1 41 b1b10012 22220041 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 13 1 40 c2c20013 44440040 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 02 1 03 b1b10002 c2c20003 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 03 1 02 c2c20003 b1b10002 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 60 1 62 e0e00060 e2e20062 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 61 1 60 e1e10061 e0e00060 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 62 1 61 e2e20062 e1e10061 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 01 1 50 77770001 66660050 3
1 0 00 00000000 0 00 00000000 0 00 00000000 1 43 1 ff 22220043 00000000 3
0 0 00 00000000 0 00 00000000 0 00 00000000 0 00 0 00 00000000 00000000 0

// ==== mpmem.f ====
source/mpmem_pkg.sv
source/mpmem_port_base.sv
source/mpmem_sram_1r1w.sv
source/mpmem_lvt.sv
source/mpmem_read_select.sv
source/mpmem_top.sv
sim/mpmem_tb.sv

// ==== Makefile ====
TOP := mpmem_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): mpmem.f source/*.sv sim/mpmem_tb.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mpmem.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^All checks passed$$" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f mpmem.f

clean:
	rm -rf obj_dir sim.log

// ==== sim/mpmem_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mpmem_tb;
  import mpmem_pkg::*;

  localparam int FIELDS    = 17;
  localparam int MAX_LINES = 64;
  localparam int RDY_EDGE  = RST_PIPE + NUMADDR + 1;
  // Falling edges from driving a read to seeing its response.
  localparam int LATENCY   = 4;

  typedef struct packed {
    logic             chk;
    logic [WIDTH-1:0] data;
    int               due;
  } pend_t;

  logic                  clk;
  logic                  rst_n;
  wr_req_t [NUMWRPT-1:0] wr_req;
  rd_req_t [NUMRDPT-1:0] rd_req;
  rd_rsp_t [NUMRDPT-1:0] rd_rsp;
  logic                  ready;

  logic [31:0] tdata [FIELDS*MAX_LINES];
  int          gap_len [MAX_LINES];
  pend_t       pend_q [NUMRDPT][$];
  int          cycle;
  int          limit;
  int          n_lines;
  int          n_checked;
  int          val_errs;
  int          proto_errs;

  mpmem_top u_mpmem_top (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp),
    .ready  (ready)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    if (limit > 0 && cycle > limit) begin
      $display("Timeout: the run went past %0d cycles", limit);
      $display("Checks failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Checking
  // ------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %08h, got %08h", $time, name, expected, actual);
      val_errs++;
    end
  endtask

  task automatic watch_responses();
    pend_t p;
    for (int r = 0; r < NUMRDPT; r++) begin
      if (rd_rsp[r].vld) begin
        if (pend_q[r].size() == 0) begin
          $display("Read port %0d gave a response at %0t ns with no read pending", r, $time);
          proto_errs++;
        end else begin
          p = pend_q[r].pop_front();
          if (p.due != cycle) begin
            $display("Read port %0d answered in cycle %0d instead of %0d", r, cycle, p.due);
            proto_errs++;
          end
          if (p.chk) begin
            check_value($sformatf("rd_rsp[%0d].dout", r), p.data, rd_rsp[r].dout);
            n_checked++;
          end
        end
      end else if (pend_q[r].size() > 0 && pend_q[r][0].due <= cycle) begin
        $display("Read port %0d: response missing %0d cycles after the read", r, LATENCY);
        proto_errs++;
        p = pend_q[r].pop_front();
      end
    end
  endtask

  // ------------------------------------------------------------
  // Driving
  // ------------------------------------------------------------

  task automatic next_cycle();
    @(negedge clk);
    cycle++;
    watch_responses();
  endtask

  task automatic drive_idle();
    wr_req = '0;
    rd_req = '0;
  endtask

  // Traffic on every port while the memory is not ready; all of it must be dropped.
  task automatic drive_dropped_traffic();
    for (int w = 0; w < NUMWRPT; w++) begin
      wr_req[w].write = 1'b1;
      wr_req[w].addr  = BITADDR'(cycle * 3 + w);
      wr_req[w].din   = {16'hdead, 16'(cycle)};
    end
    for (int r = 0; r < NUMRDPT; r++) begin
      rd_req[r].read = 1'b1;
      rd_req[r].addr = BITADDR'(cycle + r);
    end
  endtask

  task automatic drive_from_file(input int l);
    int    b;
    pend_t p;
    b = l * FIELDS;
    if (ready !== 1'b1) begin
      $display("Ready is low in cycle %0d although start-up has finished", cycle);
      proto_errs++;
    end
    for (int w = 0; w < NUMWRPT; w++) begin
      wr_req[w].write = tdata[b+1+3*w][0];
      wr_req[w].addr  = tdata[b+2+3*w][BITADDR-1:0];
      wr_req[w].din   = tdata[b+3+3*w];
    end
    for (int r = 0; r < NUMRDPT; r++) begin
      rd_req[r].read = tdata[b+10+2*r][0];
      rd_req[r].addr = tdata[b+11+2*r][BITADDR-1:0];
      if (rd_req[r].read) begin
        p.chk  = tdata[b+16][r];
        p.data = tdata[b+14+r];
        p.due  = cycle + LATENCY;
        pend_q[r].push_back(p);
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    wr_req     = '0;
    rd_req     = '0;
    cycle      = 0;
    limit      = 0;
    n_lines    = 0;
    n_checked  = 0;
    val_errs   = 0;
    proto_errs = 0;
    void'($urandom(32'hafea_0a6d));
    foreach (tdata[i]) tdata[i] = '0;
    $readmemh("sim/mpmem_testdata.txt", tdata);

    // Op 2 lines mark a section end and get a random idle gap.
    for (int l = 0; l < MAX_LINES && tdata[l*FIELDS] != 0; l++) begin
      gap_len[l] = (tdata[l*FIELDS] == 2) ? 1 + int'($urandom % 4) : 0;
      n_lines++;
    end
    limit = 16 + RDY_EDGE + 20;
    for (int l = 0; l < n_lines; l++) begin
      limit += 1 + gap_len[l];
    end

    repeat (16) begin
      next_cycle();
      drive_dropped_traffic();
    end
    rst_n = 1'b1;

    for (int k = 1; k <= RDY_EDGE; k++) begin
      next_cycle();
      if (ready !== (k == RDY_EDGE)) begin
        $display("Ready is %b at edge %0d after reset release, should rise at edge %0d",
                 ready, k, RDY_EDGE);
        proto_errs++;
      end
      if (k < RDY_EDGE) begin
        drive_dropped_traffic();
      end else begin
        drive_idle();
      end
    end

    for (int l = 0; l < n_lines; l++) begin
      if (tdata[l*FIELDS] == 2) begin
        repeat (gap_len[l]) begin
          next_cycle();
          drive_idle();
        end
      end else begin
        next_cycle();
        drive_from_file(l);
      end
    end

    repeat (LATENCY + 4) begin
      next_cycle();
      drive_idle();
    end
    for (int r = 0; r < NUMRDPT; r++) begin
      if (pend_q[r].size() != 0) begin
        $display("Read port %0d still waits for %0d responses", r, pend_q[r].size());
        proto_errs++;
      end
    end

    $display("Summary: %0d reads checked, %0d value errors, %0d other errors",
             n_checked, val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0 && n_checked > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/mpmem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mpmem_top (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  mpmem_pkg::wr_req_t [mpmem_pkg::NUMWRPT-1:0] wr_req,
  input  mpmem_pkg::rd_req_t [mpmem_pkg::NUMRDPT-1:0] rd_req,
  output mpmem_pkg::rd_rsp_t [mpmem_pkg::NUMRDPT-1:0] rd_rsp,
  output logic                                        ready
);
  import mpmem_pkg::*;

  wr_req_t [NUMWRPT-1:0]                      pwr;
  rd_req_t [NUMRDPT-1:0]                      prd;
  logic [NUMWRPT-1:0][NUMRDPT-1:0][WIDTH-1:0] bank_data;
  logic [NUMRDPT-1:0][BITWRPT-1:0]            sel;
  logic [SRAM_DELAY-1:0][NUMRDPT-1:0]         rd_pipe;
  logic [NUMRDPT-1:0]                         rd_en_d;

  mpmem_port_base u_port_base (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .pwr    (pwr),
    .prd    (prd),
    .ready  (ready)
  );

  // ------------------------------------------------------------
  // Bank array, one bank per write/read port pair
  // ------------------------------------------------------------

  for (genvar w = 0; w < NUMWRPT; w++) begin : g_wr
    for (genvar r = 0; r < NUMRDPT; r++) begin : g_rd
      mpmem_sram_1r1w u_bank (
        .clk     (clk),
        .wr      (pwr[w]),
        .rd_addr (prd[r].addr),
        .rd_en   (prd[r].read),
        .rd_data (bank_data[w][r])
      );
    end
  end

  mpmem_lvt u_lvt (
    .clk   (clk),
    .rst_n (rst_n),
    .pwr   (pwr),
    .prd   (prd),
    .sel   (sel)
  );

  // Read strobes follow the bank pipeline so the output side knows
  // when bank data is meaningful.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pipe <= '0;
    end else begin
      for (int r = 0; r < NUMRDPT; r++) begin
        rd_pipe[0][r] <= prd[r].read;
      end
      for (int i = 1; i < SRAM_DELAY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  assign rd_en_d = rd_pipe[SRAM_DELAY-1];

  mpmem_read_select u_read_select (
    .clk       (clk),
    .rst_n     (rst_n),
    .bank_data (bank_data),
    .sel       (sel),
    .rd_en_d   (rd_en_d),
    .rd_rsp    (rd_rsp)
  );

endmodule

`default_nettype wire

// ==== source/mpmem_read_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module mpmem_read_select (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [mpmem_pkg::NUMWRPT-1:0][mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::WIDTH-1:0]
                                                 bank_data,
  input  logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::BITWRPT-1:0]
                                                 sel,
  input  logic [mpmem_pkg::NUMRDPT-1:0]          rd_en_d,
  output mpmem_pkg::rd_rsp_t [mpmem_pkg::NUMRDPT-1:0]
                                                 rd_rsp
);
  import mpmem_pkg::*;

  logic [NUMRDPT-1:0][WIDTH-1:0] pick;
  logic [NUMRDPT-1:0]            vld_q;
  logic [NUMRDPT-1:0][WIDTH-1:0] dout_q;

  // Each read port has one bank per write port; the LVT says which one
  // holds the live word.
  always_comb begin
    for (int r = 0; r < NUMRDPT; r++) begin
      pick[r] = bank_data[sel[r]][r];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= rd_en_d;
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < NUMRDPT; r++) begin
      if (rd_en_d[r]) begin
        dout_q[r] <= pick[r];
      end
    end
  end

  always_comb begin
    for (int r = 0; r < NUMRDPT; r++) begin
      rd_rsp[r].vld  = vld_q[r];
      rd_rsp[r].dout = dout_q[r];
    end
  end

endmodule

`default_nettype wire

// ==== source/mpmem_lvt.sv ====
`timescale 1ns/1ns
`default_nettype none

module mpmem_lvt (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  mpmem_pkg::wr_req_t [mpmem_pkg::NUMWRPT-1:0]           pwr,
  input  mpmem_pkg::rd_req_t [mpmem_pkg::NUMRDPT-1:0]           prd,
  output logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::BITWRPT-1:0] sel
);
  import mpmem_pkg::*;

  logic [BITWRPT-1:0]                              lvt_mem [NUMADDR];
  logic [NUMRDPT-1:0][SRAM_DELAY-1:0][BITWRPT-1:0] sel_pipe;

  // ------------------------------------------------------------
  // Last writer per address
  // ------------------------------------------------------------

  // Ports are visited in ascending order, so the highest port wins
  // when several ports hit the same address on one edge.
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUMWRPT; w++) begin
      if (pwr[w].write) begin
        lvt_mem[pwr[w].addr] <= BITWRPT'(w);
      end
    end
  end

  // ------------------------------------------------------------
  // Read side, aligned with the bank pipeline
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel_pipe <= '0;
    end else begin
      for (int r = 0; r < NUMRDPT; r++) begin
        if (prd[r].read) begin
          sel_pipe[r][0] <= lvt_mem[prd[r].addr];
        end
        for (int i = 1; i < SRAM_DELAY; i++) begin
          sel_pipe[r][i] <= sel_pipe[r][i-1];
        end
      end
    end
  end

  always_comb begin
    for (int r = 0; r < NUMRDPT; r++) begin
      sel[r] = sel_pipe[r][SRAM_DELAY-1];
    end
  end

  // Every address holds a valid port index once the zero sweep is done,
  // so any read must come back with one.
  for (genvar r = 0; r < NUMRDPT; r++) begin : g_sel_chk
    a_sel_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      prd[r].read |-> ##SRAM_DELAY (sel[r] < BITWRPT'(NUMWRPT)));
  end

endmodule

`default_nettype wire

// ==== source/mpmem_sram_1r1w.sv ====
`timescale 1ns/1ns
`default_nettype none

module mpmem_sram_1r1w (
  input  logic                             clk,
  input  mpmem_pkg::wr_req_t               wr,
  input  logic [mpmem_pkg::BITADDR-1:0]    rd_addr,
  input  logic                             rd_en,
  output logic [mpmem_pkg::WIDTH-1:0]      rd_data
);
  import mpmem_pkg::*;

  logic [WIDTH-1:0]                  mem [NUMADDR];
  logic [SRAM_DELAY-1:0][WIDTH-1:0]  rd_pipe;

  always_ff @(posedge clk) begin
    if (wr.write) begin
      mem[wr.addr] <= wr.din;
    end
  end

  // A read on the same edge as a write to its address gets the old word.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pipe[0] <= mem[rd_addr];
    end
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data = rd_pipe[SRAM_DELAY-1];

  a_wr_addr_known: assert property (@(posedge clk)
    wr.write |-> !$isunknown(wr.addr));

  a_rd_addr_known: assert property (@(posedge clk)
    rd_en |-> !$isunknown(rd_addr));

endmodule

`default_nettype wire

// ==== source/mpmem_port_base.sv ====
`timescale 1ns/1ns
`default_nettype none

module mpmem_port_base (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  mpmem_pkg::wr_req_t [mpmem_pkg::NUMWRPT-1:0] wr_req,
  input  mpmem_pkg::rd_req_t [mpmem_pkg::NUMRDPT-1:0] rd_req,
  output mpmem_pkg::wr_req_t [mpmem_pkg::NUMWRPT-1:0] pwr,
  output mpmem_pkg::rd_req_t [mpmem_pkg::NUMRDPT-1:0] prd,
  output logic                                        ready
);
  import mpmem_pkg::*;

  logic [RST_PIPE-1:0] rst_pipe;
  init_state_t         state;
  init_state_t         state_nxt;
  logic [BITADDR-1:0]  clr_addr;
  logic                clr_last;
  logic                any_strobe;

  // ------------------------------------------------------------
  // Reset release and start-up sequence
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rst_pipe <= '0;
    end else begin
      rst_pipe <= {rst_pipe[RST_PIPE-2:0], 1'b1};
    end
  end

  assign clr_last = (clr_addr == BITADDR'(NUMADDR - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      INIT_WAIT: begin
        if (rst_pipe[RST_PIPE-1]) begin
          state_nxt = INIT_CLEAR;
        end
      end
      INIT_CLEAR: begin
        if (clr_last) begin
          state_nxt = INIT_RUN;
        end
      end
      INIT_RUN: begin
        state_nxt = INIT_RUN;
      end
      default: begin
        state_nxt = INIT_WAIT;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= INIT_WAIT;
      clr_addr <= '0;
    end else begin
      state <= state_nxt;
      if (state == INIT_CLEAR) begin
        clr_addr <= clr_addr + 1'b1;
      end
    end
  end

  assign ready = (state == INIT_RUN);

  // ------------------------------------------------------------
  // Input flop
  // ------------------------------------------------------------

  // The sweep borrows write port 0 while the other strobes stay low.
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUMWRPT; w++) begin
      pwr[w].addr <= wr_req[w].addr;
      pwr[w].din  <= wr_req[w].din;
    end
    for (int r = 0; r < NUMRDPT; r++) begin
      prd[r].addr <= rd_req[r].addr;
    end
    if (state == INIT_CLEAR) begin
      pwr[0].addr <= clr_addr;
      pwr[0].din  <= '0;
    end

    if (!rst_n) begin
      for (int w = 0; w < NUMWRPT; w++) begin
        pwr[w].write <= 1'b0;
      end
      for (int r = 0; r < NUMRDPT; r++) begin
        prd[r].read <= 1'b0;
      end
    end else begin
      for (int w = 0; w < NUMWRPT; w++) begin
        pwr[w].write <= wr_req[w].write & ready;
      end
      for (int r = 0; r < NUMRDPT; r++) begin
        prd[r].read <= rd_req[r].read & ready;
      end
      if (state == INIT_CLEAR) begin
        pwr[0].write <= 1'b1;
      end
    end
  end

  always_comb begin
    any_strobe = 1'b0;
    for (int w = 0; w < NUMWRPT; w++) begin
      any_strobe = any_strobe | pwr[w].write;
    end
    for (int r = 0; r < NUMRDPT; r++) begin
      any_strobe = any_strobe | prd[r].read;
    end
  end

  // Requests seen before ready must never reach the banks.
  a_no_strobe_before_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (!ready && state != INIT_CLEAR) |-> !any_strobe);

endmodule

`default_nettype wire

// ==== source/mpmem_pkg.sv ====
`default_nettype none

package mpmem_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------

  localparam int WIDTH   = 32;
  localparam int NUMWRPT = 3;
  localparam int NUMRDPT = 2;
  localparam int NUMADDR = 256;
  localparam int BITADDR = 8;
  localparam int BITWRPT = 2;

  // ------------------------------------------------------------
  // Latencies
  // ------------------------------------------------------------

  // Read latency of one bank, counted from the registered address.
  localparam int SRAM_DELAY = 2;

  // Cycles between reset release and the start of the zero sweep.
  localparam int RST_PIPE = 3;

  // ------------------------------------------------------------
  // Port records
  // ------------------------------------------------------------

  typedef struct packed {
    logic               write;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   din;
  } wr_req_t;

  typedef struct packed {
    logic               read;
    logic [BITADDR-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic             vld;
    logic [WIDTH-1:0] dout;
  } rd_rsp_t;

  // Start-up sequence of the input side.
  typedef enum logic [1:0] {
    INIT_WAIT,
    INIT_CLEAR,
    INIT_RUN
  } init_state_t;

endpackage

`default_nettype wire
